// ==== hw/rv_isa_pkg.sv ====
// RV64I encodings and the decoder/execute control codes shared by the IDU and the EXU
package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm32  = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg32  = 7'b0111011;
  localparam logic [6:0] op_system = 7'b1110011;

  // alu control
  localparam logic [4:0] alu_copyimm = 5'b00011;
  localparam logic [4:0] alu_add     = 5'b00000;
  localparam logic [4:0] alu_sub     = 5'b01000;
  localparam logic [4:0] alu_sltu    = 5'b01010;
  localparam logic [4:0] alu_xor     = 5'b00100;
  localparam logic [4:0] alu_and     = 5'b00111;
  localparam logic [4:0] alu_or      = 5'b00110;
  localparam logic [4:0] alu_sll     = 5'b00001;
  localparam logic [4:0] alu_srl     = 5'b00101;
  localparam logic [4:0] alu_sra     = 5'b01101;
  localparam logic [4:0] alu_ebreak  = 5'b11110;
  localparam logic [4:0] alu_invalid = 5'b11111;

  // branch kinds, unsigned compare carried on a separate bit
  localparam logic [2:0] br_none = 3'b000;
  localparam logic [2:0] br_jal  = 3'b001;
  localparam logic [2:0] br_jalr = 3'b010;
  localparam logic [2:0] br_eq   = 3'b100;
  localparam logic [2:0] br_ne   = 3'b101;
  localparam logic [2:0] br_lt   = 3'b110;
  localparam logic [2:0] br_ge   = 3'b111;

  // immediate formats
  localparam logic [2:0] ext_i = 3'b000;
  localparam logic [2:0] ext_u = 3'b001;
  localparam logic [2:0] ext_s = 3'b010;
  localparam logic [2:0] ext_b = 3'b011;
  localparam logic [2:0] ext_j = 3'b100;

  // alu operand b source
  localparam logic [1:0] bsrc_rs2  = 2'b00;
  localparam logic [1:0] bsrc_imm  = 2'b01;
  localparam logic [1:0] bsrc_four = 2'b10;

endpackage

// ==== hw/core_cfg_pkg.sv ====
// core sizing and reset configuration, referenced by the RTL and the testbench
package core_cfg_pkg;

  localparam int xlen     = 64;
  localparam int nr_regs  = 32;
  localparam int inst_w   = 32;
  localparam int wb_adr_w = 32;

  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000; // first fetch address

endpackage

// ==== hw/mux_key.sv ====
// keyed lookup mux with default, payload type chosen per instance
`timescale 1ns/1ns

module mux_key #(
  parameter int  nr_key  = 2,
  parameter int  key_len = 1,
  parameter type data_t  = logic
) (
  input  logic [key_len-1:0] i_key,
  input  logic [key_len-1:0] i_keys [nr_key],
  input  data_t              i_datas [nr_key],
  input  data_t              i_default,
  output data_t              o_out
);

  logic [nr_key-1:0] hit;
  data_t             acc;

  always_comb begin
    for (int k = 0; k < nr_key; k++) begin
      hit[k] = (i_keys[k] == i_key);
    end
  end

  always_comb begin
    acc = '0;
    for (int k = 0; k < nr_key; k++) begin
      acc = acc | ({$bits(data_t){hit[k]}} & i_datas[k]); // and-or, no priority
    end
    o_out = (|hit) ? acc : i_default;
  end

  // table entries must be unique or the and-or merges payloads
  a_one_match: assert #0 ($isunknown(i_key) || $onehot0(hit));

endmodule

// ==== hw/rv_idu.sv ====
// RV64I instruction decoder, turns one fetched word into operands and controls for the EXU
`timescale 1ns/1ns

module rv_idu (
  input  logic [core_cfg_pkg::inst_w-1:0] i_inst,
  output logic [4:0]                      o_ra,
  output logic [4:0]                      o_rb,
  output logic [4:0]                      o_rd,
  output logic [core_cfg_pkg::xlen-1:0]   o_imm,
  output logic [4:0]                      o_alu_ctr,
  output logic                            o_alu_asrc,
  output logic [1:0]                      o_alu_bsrc,
  output logic [2:0]                      o_branch,
  output logic                            o_br_unsigned,
  output logic                            o_word_cut,
  output logic                            o_reg_wr,
  output logic                            o_illegal
);

  logic [6:0]                    opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [2:0]                    ext_op;
  logic [core_cfg_pkg::xlen-1:0] imm_i, imm_u, imm_s, imm_b, imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  wire is_imm   = (opcode == rv_isa_pkg::op_imm);
  wire is_imm32 = (opcode == rv_isa_pkg::op_imm32);
  wire is_reg   = (opcode == rv_isa_pkg::op_reg);
  wire is_reg32 = (opcode == rv_isa_pkg::op_reg32);
  wire is_br    = (opcode == rv_isa_pkg::op_branch);
  wire f7_zero  = (funct7 == 7'b0000000);
  wire f7_alt   = (funct7 == 7'b0100000);

  wire inst_lui    = (opcode == rv_isa_pkg::op_lui);
  wire inst_auipc  = (opcode == rv_isa_pkg::op_auipc);
  wire inst_jal    = (opcode == rv_isa_pkg::op_jal);
  wire inst_jalr   = (opcode == rv_isa_pkg::op_jalr) & (funct3 == 3'b000);
  wire inst_beq    = is_br & (funct3 == 3'b000);
  wire inst_bne    = is_br & (funct3 == 3'b001);
  wire inst_blt    = is_br & (funct3 == 3'b100);
  wire inst_bge    = is_br & (funct3 == 3'b101);
  wire inst_bltu   = is_br & (funct3 == 3'b110);
  wire inst_bgeu   = is_br & (funct3 == 3'b111);
  wire inst_addi   = is_imm & (funct3 == 3'b000);
  wire inst_sltiu  = is_imm & (funct3 == 3'b011);
  wire inst_xori   = is_imm & (funct3 == 3'b100);
  wire inst_andi   = is_imm & (funct3 == 3'b111);
  wire inst_slli   = is_imm & (funct3 == 3'b001) & (funct7[6:1] == 6'b000000); // 6-bit shamt
  wire inst_srli   = is_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b000000);
  wire inst_srai   = is_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b010000);
  wire inst_add    = is_reg & (funct3 == 3'b000) & f7_zero;
  wire inst_sub    = is_reg & (funct3 == 3'b000) & f7_alt;
  wire inst_or     = is_reg & (funct3 == 3'b110) & f7_zero;
  wire inst_addiw  = is_imm32 & (funct3 == 3'b000);
  wire inst_slliw  = is_imm32 & (funct3 == 3'b001) & f7_zero;
  wire inst_srliw  = is_imm32 & (funct3 == 3'b101) & f7_zero;
  wire inst_sraiw  = is_imm32 & (funct3 == 3'b101) & f7_alt;
  wire inst_addw   = is_reg32 & (funct3 == 3'b000) & f7_zero;
  wire inst_subw   = is_reg32 & (funct3 == 3'b000) & f7_alt;
  wire inst_sllw   = is_reg32 & (funct3 == 3'b001) & f7_zero;
  wire inst_srlw   = is_reg32 & (funct3 == 3'b101) & f7_zero;
  wire inst_sraw   = is_reg32 & (funct3 == 3'b101) & f7_alt;
  wire inst_ebreak = (opcode == rv_isa_pkg::op_system) & (i_inst[31:7] == 25'h0002000);

  wire type_r = |{inst_add, inst_sub, inst_or, inst_addw, inst_subw,
                  inst_sllw, inst_srlw, inst_sraw};
  wire type_i = |{inst_jalr, inst_addi, inst_sltiu, inst_xori, inst_andi, inst_slli,
                  inst_srli, inst_srai, inst_addiw, inst_slliw, inst_srliw, inst_sraiw,
                  inst_ebreak};
  wire type_u = inst_lui | inst_auipc;
  wire type_b = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};
  wire type_j = inst_jal;

  assign o_illegal     = ~|{type_r, type_i, type_u, type_b, type_j};
  assign o_reg_wr      = |{type_r, type_i & ~inst_ebreak, type_u, type_j};
  assign o_alu_asrc    = inst_jal | inst_jalr | inst_auipc; // pc as operand a
  assign o_alu_bsrc    = (inst_jal | inst_jalr) ? rv_isa_pkg::bsrc_four :
                         (type_i | type_u)      ? rv_isa_pkg::bsrc_imm  : rv_isa_pkg::bsrc_rs2;
  assign o_br_unsigned = inst_bltu | inst_bgeu;
  assign o_word_cut    = |{inst_addiw, inst_slliw, inst_srliw, inst_sraiw, inst_addw,
                           inst_subw, inst_sllw, inst_srlw, inst_sraw};

  mux_key #(.nr_key(4), .key_len(4), .data_t(logic [2:0])) u_ext_mux (
    .i_key     ({type_i, type_u, type_b, type_j}),
    .i_keys    ('{4'b1000, 4'b0100, 4'b0010, 4'b0001}),
    .i_datas   ('{rv_isa_pkg::ext_i, rv_isa_pkg::ext_u, rv_isa_pkg::ext_b, rv_isa_pkg::ext_j}),
    .i_default (rv_isa_pkg::ext_i),
    .o_out     (ext_op)
  );

  mux_key #(.nr_key(5), .key_len(3), .data_t(logic [core_cfg_pkg::xlen-1:0])) u_imm_mux (
    .i_key     (ext_op),
    .i_keys    ('{rv_isa_pkg::ext_i, rv_isa_pkg::ext_u, rv_isa_pkg::ext_s,
                  rv_isa_pkg::ext_b, rv_isa_pkg::ext_j}),
    .i_datas   ('{imm_i, imm_u, imm_s, imm_b, imm_j}),
    .i_default ('0),
    .o_out     (o_imm)
  );

  mux_key #(.nr_key(11), .key_len(11), .data_t(logic [4:0])) u_alu_mux (
    .i_key     ({inst_lui,
                 |{inst_auipc, inst_jal, inst_jalr, inst_addi, inst_add, inst_addiw, inst_addw},
                 |{type_b, inst_sub, inst_subw},
                 inst_sltiu, inst_xori, inst_andi, inst_or,
                 |{inst_slli, inst_slliw, inst_sllw},
                 |{inst_srli, inst_srliw, inst_srlw},
                 |{inst_srai, inst_sraiw, inst_sraw},
                 inst_ebreak}),
    .i_keys    ('{11'b10000000000, 11'b01000000000, 11'b00100000000, 11'b00010000000,
                  11'b00001000000, 11'b00000100000, 11'b00000010000, 11'b00000001000,
                  11'b00000000100, 11'b00000000010, 11'b00000000001}),
    .i_datas   ('{rv_isa_pkg::alu_copyimm, rv_isa_pkg::alu_add, rv_isa_pkg::alu_sub,
                  rv_isa_pkg::alu_sltu, rv_isa_pkg::alu_xor, rv_isa_pkg::alu_and,
                  rv_isa_pkg::alu_or, rv_isa_pkg::alu_sll, rv_isa_pkg::alu_srl,
                  rv_isa_pkg::alu_sra, rv_isa_pkg::alu_ebreak}),
    .i_default (rv_isa_pkg::alu_invalid),
    .o_out     (o_alu_ctr)
  );

  mux_key #(.nr_key(8), .key_len(8), .data_t(logic [2:0])) u_br_mux (
    .i_key     ({inst_jal, inst_jalr, inst_beq, inst_bne,
                 inst_blt, inst_bge, inst_bltu, inst_bgeu}),
    .i_keys    ('{8'b10000000, 8'b01000000, 8'b00100000, 8'b00010000,
                  8'b00001000, 8'b00000100, 8'b00000010, 8'b00000001}),
    .i_datas   ('{rv_isa_pkg::br_jal, rv_isa_pkg::br_jalr, rv_isa_pkg::br_eq, rv_isa_pkg::br_ne,
                  rv_isa_pkg::br_lt, rv_isa_pkg::br_ge, rv_isa_pkg::br_lt, rv_isa_pkg::br_ge}),
    .i_default (rv_isa_pkg::br_none),
    .o_out     (o_branch)
  );

endmodule

// ==== hw/rv_regfile.sv ====
// integer register file, two async read ports and one clocked write port, x0 reads zero
`timescale 1ns/1ns

module rv_regfile (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic [4:0]                    i_ra,
  input  logic [4:0]                    i_rb,
  input  logic                          i_we,
  input  logic [4:0]                    i_wa,
  input  logic [core_cfg_pkg::xlen-1:0] i_wd,
  output logic [core_cfg_pkg::xlen-1:0] o_rda,
  output logic [core_cfg_pkg::xlen-1:0] o_rdb
);

  logic [core_cfg_pkg::xlen-1:0] regs [core_cfg_pkg::nr_regs];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int r = 0; r < core_cfg_pkg::nr_regs; r++) begin
        regs[r] <= '0;
      end
    end else if (i_we && i_wa != 5'd0) begin
      regs[i_wa] <= i_wd; // x0 writes dropped
    end
  end

  assign o_rda = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_rdb = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

// ==== hw/rv_exu.sv ====
// execute unit, ALU with word cut plus branch and jump next-pc resolution
`timescale 1ns/1ns

module rv_exu (
  input  logic [core_cfg_pkg::xlen-1:0] i_pc,
  input  logic [core_cfg_pkg::xlen-1:0] i_rs1,
  input  logic [core_cfg_pkg::xlen-1:0] i_rs2,
  input  logic [core_cfg_pkg::xlen-1:0] i_imm,
  input  logic [4:0]                    i_alu_ctr,
  input  logic                          i_alu_asrc,
  input  logic [1:0]                    i_alu_bsrc,
  input  logic [2:0]                    i_branch,
  input  logic                          i_br_unsigned,
  input  logic                          i_word_cut,
  output logic [core_cfg_pkg::xlen-1:0] o_result,
  output logic [core_cfg_pkg::xlen-1:0] o_next_pc
);

  logic [core_cfg_pkg::xlen-1:0] op_a, op_b, a_zx, a_sx, alu;
  logic [5:0]                    shamt;
  logic                          eq, lt, taken;

  assign op_a = i_alu_asrc ? i_pc : i_rs1;

  always_comb begin
    case (i_alu_bsrc)
      rv_isa_pkg::bsrc_imm:  op_b = i_imm;
      rv_isa_pkg::bsrc_four: op_b = 64'd4;
      default:               op_b = i_rs2;
    endcase
  end

  // word shifts see only the low half of a and 5 bits of shamt
  assign shamt = i_word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];
  assign a_zx  = i_word_cut ? {32'b0, op_a[31:0]} : op_a;
  assign a_sx  = i_word_cut ? {{32{op_a[31]}}, op_a[31:0]} : op_a;

  always_comb begin
    case (i_alu_ctr)
      rv_isa_pkg::alu_copyimm: alu = op_b;
      rv_isa_pkg::alu_add:     alu = op_a + op_b;
      rv_isa_pkg::alu_sub:     alu = op_a - op_b;
      rv_isa_pkg::alu_sltu:    alu = {63'b0, op_a < op_b};
      rv_isa_pkg::alu_xor:     alu = op_a ^ op_b;
      rv_isa_pkg::alu_and:     alu = op_a & op_b;
      rv_isa_pkg::alu_or:      alu = op_a | op_b;
      rv_isa_pkg::alu_sll:     alu = op_a << shamt;
      rv_isa_pkg::alu_srl:     alu = a_zx >> shamt;
      rv_isa_pkg::alu_sra:     alu = $signed(a_sx) >>> shamt;
      default:                 alu = '0; // ebreak and invalid write nothing
    endcase
  end

  assign o_result = i_word_cut ? {{32{alu[31]}}, alu[31:0]} : alu;

  assign eq = (i_rs1 == i_rs2);
  assign lt = i_br_unsigned ? (i_rs1 < i_rs2) : ($signed(i_rs1) < $signed(i_rs2));

  always_comb begin
    case (i_branch)
      rv_isa_pkg::br_jal: taken = 1'b1;
      rv_isa_pkg::br_eq:  taken = eq;
      rv_isa_pkg::br_ne:  taken = ~eq;
      rv_isa_pkg::br_lt:  taken = lt;
      rv_isa_pkg::br_ge:  taken = ~lt;
      default:            taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_branch == rv_isa_pkg::br_jalr) begin
      o_next_pc = (i_rs1 + i_imm) & ~64'd1;
    end else if (taken) begin
      o_next_pc = i_pc + i_imm;
    end else begin
      o_next_pc = i_pc + 64'd4;
    end
  end

endmodule

// ==== hw/rv_ifu_wb.sv ====
// fetch unit, owns the pc and instruction register and runs the Wishbone classic read cycle
`timescale 1ns/1ns

module rv_ifu_wb (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic [core_cfg_pkg::inst_w-1:0]   i_wb_dat,
  input  logic                              i_wb_ack,
  input  logic [core_cfg_pkg::xlen-1:0]     i_next_pc,
  input  logic                              i_stop,
  input  logic                              i_illegal,
  output logic                              o_wb_cyc,
  output logic                              o_wb_stb,
  output logic [core_cfg_pkg::wb_adr_w-1:0] o_wb_adr,
  output logic [core_cfg_pkg::inst_w-1:0]   o_inst,
  output logic [core_cfg_pkg::xlen-1:0]     o_pc,
  output logic                              o_retire,
  output logic                              o_halt,
  output logic                              o_illegal
);

  typedef enum logic [1:0] {st_fetch, st_exec, st_halt} state_t;

  state_t state;
  logic   cyc;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= st_fetch;
      cyc       <= 1'b0;
      o_pc      <= core_cfg_pkg::reset_pc;
      o_illegal <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (!cyc) begin
            cyc <= 1'b1; // only right after reset
          end else if (i_wb_ack) begin
            cyc   <= 1'b0;
            state <= st_exec;
          end
        end
        st_exec: begin
          o_pc <= i_next_pc;
          if (i_stop || i_illegal) begin
            state     <= st_halt;
            o_illegal <= i_illegal;
          end else begin
            state <= st_fetch;
            cyc   <= 1'b1; // next request right after retire
          end
        end
        default: begin
          state <= st_halt; // stuck until reset
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == st_fetch && cyc && i_wb_ack) begin
      o_inst <= i_wb_dat;
    end
  end

  assign o_wb_cyc = cyc;
  assign o_wb_stb = cyc;
  assign o_wb_adr = o_pc[core_cfg_pkg::wb_adr_w-1:0];
  assign o_retire = (state == st_exec);
  assign o_halt   = (state == st_halt);

  // request held with stb until the slave answers
  a_cyc_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_wb_cyc && !i_wb_ack) |=> (o_wb_cyc && o_wb_stb));

  a_retire_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_retire |=> !o_retire);

endmodule

// ==== hw/rv_core_top.sv ====
// RV64I core top, joins fetch, decode, register file and execute behind one Wishbone fetch port
`timescale 1ns/1ns

module rv_core_top (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic [core_cfg_pkg::inst_w-1:0]   i_wb_dat,
  input  logic                              i_wb_ack,
  output logic                              o_wb_cyc,
  output logic                              o_wb_stb,
  output logic [core_cfg_pkg::wb_adr_w-1:0] o_wb_adr,
  output logic                              o_retire,
  output logic [core_cfg_pkg::xlen-1:0]     o_retire_pc,
  output logic [4:0]                        o_retire_rd,
  output logic                              o_retire_we,
  output logic [core_cfg_pkg::xlen-1:0]     o_retire_data,
  output logic                              o_halt,
  output logic                              o_illegal
);

  logic [core_cfg_pkg::inst_w-1:0] inst;
  logic [core_cfg_pkg::xlen-1:0]   imm, rs1, rs2, next_pc;
  logic [4:0]                      ra, rb, alu_ctr;
  logic [2:0]                      branch;
  logic [1:0]                      alu_bsrc;
  logic                            alu_asrc, br_unsigned, word_cut, reg_wr, dec_illegal;

  assign o_retire_we = reg_wr & o_retire; // also the regfile write strobe

  rv_ifu_wb u_ifu (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wb_dat  (i_wb_dat),
    .i_wb_ack  (i_wb_ack),
    .i_next_pc (next_pc),
    .i_stop    (alu_ctr == rv_isa_pkg::alu_ebreak),
    .i_illegal (dec_illegal),
    .o_wb_cyc  (o_wb_cyc),
    .o_wb_stb  (o_wb_stb),
    .o_wb_adr  (o_wb_adr),
    .o_inst    (inst),
    .o_pc      (o_retire_pc),
    .o_retire  (o_retire),
    .o_halt    (o_halt),
    .o_illegal (o_illegal)
  );

  rv_idu u_idu (
    .i_inst        (inst),
    .o_ra          (ra),
    .o_rb          (rb),
    .o_rd          (o_retire_rd),
    .o_imm         (imm),
    .o_alu_ctr     (alu_ctr),
    .o_alu_asrc    (alu_asrc),
    .o_alu_bsrc    (alu_bsrc),
    .o_branch      (branch),
    .o_br_unsigned (br_unsigned),
    .o_word_cut    (word_cut),
    .o_reg_wr      (reg_wr),
    .o_illegal     (dec_illegal)
  );

  rv_regfile u_regfile (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ra    (ra),
    .i_rb    (rb),
    .i_we    (o_retire_we),
    .i_wa    (o_retire_rd),
    .i_wd    (o_retire_data),
    .o_rda   (rs1),
    .o_rdb   (rs2)
  );

  rv_exu u_exu (
    .i_pc          (o_retire_pc),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_imm         (imm),
    .i_alu_ctr     (alu_ctr),
    .i_alu_asrc    (alu_asrc),
    .i_alu_bsrc    (alu_bsrc),
    .i_branch      (branch),
    .i_br_unsigned (br_unsigned),
    .i_word_cut    (word_cut),
    .o_result      (o_retire_data),
    .o_next_pc     (next_pc)
  );

endmodule

// ==== tb/rv_core_checker.sv ====
// testbench checker that compares retirements and the halt state with the expected records
`timescale 1ns/1ns

module rv_core_checker (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_retire,
  input  logic [core_cfg_pkg::xlen-1:0] i_retire_pc,
  input  logic [4:0]                    i_retire_rd,
  input  logic                          i_retire_we,
  input  logic [core_cfg_pkg::xlen-1:0] i_retire_data,
  input  logic                          i_halt,
  input  logic                          i_illegal,
  input  logic [63:0]                   i_exp_pc,
  input  logic [63:0]                   i_exp_meta,
  input  logic [63:0]                   i_exp_data,
  input  logic [63:0]                   i_exp_halt_pc,
  input  logic                          i_exp_illegal,
  input  int                            i_nr_recs,
  output int                            o_rec_idx,
  output int                            o_err_cnt,
  output int                            o_chk_cnt
);

  logic halt_seen;

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    o_chk_cnt = o_chk_cnt + 1;
    if (got !== exp) begin
      o_err_cnt = o_err_cnt + 1;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  initial begin
    o_err_cnt = 0;
    o_chk_cnt = 0;
  end

  // mid-cycle sampling, retire and halt are stable here
  always @(negedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rec_idx <= 0;
      halt_seen <= 1'b0;
    end else begin
      if (i_retire && halt_seen) begin
        o_err_cnt = o_err_cnt + 1;
        $display("retirement at pc %h after the core halted", i_retire_pc);
      end else if (i_retire && o_rec_idx >= i_nr_recs) begin
        o_err_cnt = o_err_cnt + 1;
        $display("retirement at pc %h past the expected list, halt missing", i_retire_pc);
      end else if (i_retire) begin
        compare_field("o_retire_pc", i_retire_pc, i_exp_pc);
        compare_field("o_retire_we", i_retire_we, i_exp_meta[0]);
        if (i_exp_meta[0]) begin // rd and data only matter on a write
          compare_field("o_retire_rd", i_retire_rd, i_exp_meta[8:4]);
          compare_field("o_retire_data", i_retire_data, i_exp_data);
        end
        o_rec_idx <= o_rec_idx + 1;
      end
      if (i_halt && !halt_seen) begin
        halt_seen <= 1'b1;
        if (o_rec_idx != i_nr_recs) begin
          o_err_cnt = o_err_cnt + 1;
          $display("halt after %0d retirements where %0d were expected", o_rec_idx, i_nr_recs);
        end
        compare_field("o_retire_pc", i_retire_pc, i_exp_halt_pc); // pc after the last one
        compare_field("o_illegal", i_illegal, i_exp_illegal);
      end
    end
  end

endmodule

// ==== tb/tb_rv_core.sv ====
// testbench top, runs each program segment of the case file on the core behind a Wishbone slave
`timescale 1ns/1ns

module tb_rv_core;

  localparam int clk_period = 100;
  localparam int drive_dly  = 2; // after the rising edge

  logic                              clk;
  logic                              rst_n;
  logic [core_cfg_pkg::inst_w-1:0]   wb_dat;
  logic                              wb_ack;
  logic                              wb_cyc, wb_stb;
  logic [core_cfg_pkg::wb_adr_w-1:0] wb_adr;
  logic                              retire, retire_we, halt, illegal;
  logic [4:0]                        retire_rd;
  logic [core_cfg_pkg::xlen-1:0]     retire_pc, retire_data;
  logic [63:0]                       exp_pc, exp_meta, exp_data, exp_halt_pc;
  logic                              exp_illegal;
  logic [63:0]                       cases [256];
  logic [31:0]                       lfsr;
  logic                              busy;
  int                                seg_base, nr_prog, nr_recs, rec_base, rec_idx;
  int                                err_cnt, chk_cnt, cycles, cycle_limit, wait_left;

  // records are pc, meta, data triples
  assign exp_pc      = cases[rec_base + 3 * rec_idx];
  assign exp_meta    = cases[rec_base + 3 * rec_idx + 1];
  assign exp_data    = cases[rec_base + 3 * rec_idx + 2];
  assign exp_halt_pc = cases[rec_base + 3 * nr_recs];
  assign exp_illegal = cases[rec_base + 3 * nr_recs + 1][0];

  rv_core_top dut0 (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_wb_dat      (wb_dat),
    .i_wb_ack      (wb_ack),
    .o_wb_cyc      (wb_cyc),
    .o_wb_stb      (wb_stb),
    .o_wb_adr      (wb_adr),
    .o_retire      (retire),
    .o_retire_pc   (retire_pc),
    .o_retire_rd   (retire_rd),
    .o_retire_we   (retire_we),
    .o_retire_data (retire_data),
    .o_halt        (halt),
    .o_illegal     (illegal)
  );

  rv_core_checker u_checker (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_retire (retire), .i_retire_pc (retire_pc), .i_retire_rd (retire_rd),
    .i_retire_we (retire_we), .i_retire_data (retire_data),
    .i_halt (halt), .i_illegal (illegal),
    .i_exp_pc (exp_pc), .i_exp_meta (exp_meta), .i_exp_data (exp_data),
    .i_exp_halt_pc (exp_halt_pc), .i_exp_illegal (exp_illegal), .i_nr_recs (nr_recs),
    .o_rec_idx (rec_idx), .o_err_cnt (err_cnt), .o_chk_cnt (chk_cnt)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
  endfunction

  task automatic draw_wait(output int n);
    lfsr = lfsr_next(lfsr);
    n = lfsr[0];
    lfsr = lfsr_next(lfsr);
    n = n + 2 * lfsr[0];
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    logic [31:0] idx;
    idx = (adr - core_cfg_pkg::reset_pc[31:0]) >> 2;
    if (idx < nr_prog) begin
      return cases[seg_base + 2 + idx][31:0];
    end
    return 32'h0; // outside the program, decodes as illegal
  endfunction

  function automatic int count_records();
    int base;
    int total;
    base = 0;
    total = 0;
    while (cases[base] != 0) begin
      total = total + cases[base + 1] + 1; // plus the halt record
      base = base + 2 + cases[base] + 3 * (cases[base + 1] + 1);
    end
    return total;
  endfunction

  task automatic apply_reset();
    #drive_dly;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Wishbone classic slave, 0 to 3 wait cycles then a one-cycle ack
  always @(posedge clk) begin
    #drive_dly;
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        draw_wait(wait_left);
      end
      if (wait_left == 0) begin
        wb_dat = fetch_word(wb_adr);
        wb_ack = 1'b1;
        busy   = 1'b0;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  initial begin
    wait (cycle_limit > 0);
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("timeout: core did not halt within %0d cycles", cycle_limit);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n     = 1'b1;
    wb_ack    = 1'b0;
    wb_dat    = '0;
    busy      = 1'b0;
    wait_left = 0;
    lfsr      = 32'hc4b4a1d0;
    seg_base  = 0;
    $readmemh("tb/rv_core_cases.txt", cases);
    cycle_limit = count_records() * 8 + 50;
    while (cases[seg_base] != 0) begin
      nr_prog  = cases[seg_base];
      nr_recs  = cases[seg_base + 1];
      rec_base = seg_base + 2 + nr_prog;
      apply_reset();
      wait (halt === 1'b1);
      repeat (3) @(posedge clk); // stray retirements would show here
      seg_base = rec_base + 3 * (nr_recs + 1);
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/rv_core_cases.txt ====
// segment: prog word count, record count, program words, then records of pc, rd*16+we, data
// then a halt record of halt pc, illegal, 0; a zero count ends the file
25 20
123450b7 fff00113 002081b3 40208233 0030e2b3 fff0b313 7ff0c393 0f017413
03f11493 03c4d513 43c4d593 00001617 0030969b 0006071b 0046579b 4046581b
001688bb 4010093b 002319bb 00265a3b 40265abb 00508013 00000b33 00108463
00100b93 00109463 00114463 00100b93 00115463 00116463 00117463 00100b93
00800c6f 00100b93 00dc0ce7 00100b93 00100073
80000000 11 12345000          80000004 21 ffffffffffffffff
80000008 31 12344fff          8000000c 41 12345001
80000010 51 12345fff          80000014 61 1
80000018 71 123457ff          8000001c 81 f0
80000020 91 8000000000000000  80000024 a1 8
80000028 b1 fffffffffffffff8  8000002c c1 8000102c
80000030 d1 ffffffff91a28000  80000034 e1 ffffffff8000102c
80000038 f1 08000102          8000003c 101 fffffffff8000102
80000040 111 ffffffffa3d6d000 80000044 121 ffffffffedcbb000
80000048 131 ffffffff80000000 8000004c 141 1
80000050 151 ffffffffffffffff 80000054 1 12345005
80000058 161 0                8000005c 0 0
80000064 0 0                  80000068 0 0
80000070 0 0                  80000074 0 0
80000078 0 0                  80000080 181 80000084
80000088 191 8000008c         80000090 0 0
80000094 0 0
3 3
00700093 ff80811b 00013183
80000000 11 7                 80000004 21 ffffffffffffffff
80000008 0 0
8000000c 1 0
0 0

// ==== filelist.f ====
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/mux_key.sv
hw/rv_idu.sv
hw/rv_regfile.sv
hw/rv_exu.sv
hw/rv_ifu_wb.sv
hw/rv_core_top.sv
tb/rv_core_checker.sv
tb/tb_rv_core.sv
